/* hdl/sqrt_cfg.svh */
`ifndef SQRT_CFG_SVH
`define SQRT_CFG_SVH

// Root is half the radicand width
`define SQRT_RAD_W      16
`define SQRT_ROOT_W     8

// Result RAM geometry
`define SQRT_ADDR_W     12
`define SQRT_WORD_W     16
`define SQRT_RAM_DEPTH  (1 << `SQRT_ADDR_W)

`endif

/* hdl/sqrt_pkg.sv */
`include "sqrt_cfg.svh"

package sqrt_pkg;

    // One byte on either queue
    typedef logic [7:0]              byte_t;
    typedef logic [`SQRT_RAD_W-1:0]  rad_t;
    typedef logic [`SQRT_ROOT_W-1:0] root_t;
    typedef logic [`SQRT_ADDR_W-1:0] addr_t;
    typedef logic [`SQRT_WORD_W-1:0] word_t;

    // One parsed command held until its reply is sent
    typedef struct packed {
        addr_t addr;
        rad_t  radicand;
    } sqrt_cmd_t;

    typedef enum logic [3:0] {
        ADDR_HI, ADDR_LO, RAD_HI, RAD_LO,
        ROOT_WAIT, RAM_WRITE, RAM_READ,
        TX_HI, TX_LO
    } ctrl_state_t;

endpackage

/* hdl/isqrt_unit.sv */
`timescale 1ns/1ps
`include "sqrt_cfg.svh"

module isqrt_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  sqrt_pkg::rad_t  radicand,
    output sqrt_pkg::root_t root,
    output logic            done
);

    localparam int ROOT_W = `SQRT_ROOT_W;
    localparam int RAD_W  = `SQRT_RAD_W;
    localparam int REM_W  = ROOT_W + 2;
    localparam int CNT_W  = (ROOT_W > 1) ? $clog2(ROOT_W) : 1;
    localparam int LAST   = ROOT_W - 1;

    logic             busy;
    logic [CNT_W-1:0] bit_cnt;
    logic             step;

    sqrt_pkg::rad_t   rad_q;
    logic [REM_W-1:0] rem_q;
    sqrt_pkg::root_t  root_q;

    // Operands of the current iteration
    sqrt_pkg::rad_t   rad_in;
    logic [REM_W-1:0] rem_in;
    sqrt_pkg::root_t  root_in;

    logic [REM_W+1:0] rem_sh;
    logic [REM_W+1:0] trial;
    logic [REM_W+1:0] diff;
    logic             fits;

    //////////////////////////////
    // One restoring iteration
    //////////////////////////////

    // First iteration runs on the start edge from fresh operands
    assign rad_in  = busy ? rad_q  : radicand;
    assign rem_in  = busy ? rem_q  : '0;
    assign root_in = busy ? root_q : '0;

    // Bring down the next two radicand bits
    assign rem_sh = {rem_in, rad_in[RAD_W-1 -: 2]};
    assign trial  = {2'b00, root_in, 2'b01};
    assign diff   = rem_sh - trial;
    assign fits   = (rem_sh >= trial);

    assign step = busy || start;

    always_ff @(posedge clk) begin
        if (step) begin
            rad_q  <= rad_in << 2;
            rem_q  <= fits ? diff[REM_W-1:0] : rem_sh[REM_W-1:0];
            root_q <= {root_in[ROOT_W-2:0], fits};
        end
    end

    //////////////////////////////
    // Iteration control
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy    <= 1'b1;
                bit_cnt <= CNT_W'(1);
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                // Final bit lands on this edge
                if (bit_cnt == CNT_W'(LAST)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    assign root = root_q;

    // Controller must wait for done before the next command
    a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
        !(start && busy));

endmodule

/* hdl/result_ram.sv */
`timescale 1ns/1ps
`include "sqrt_cfg.svh"

module result_ram (
    input  logic            clk,
    input  logic            we,
    input  sqrt_pkg::addr_t addr,
    input  sqrt_pkg::word_t wdata,
    output sqrt_pkg::word_t rdata
);

    sqrt_pkg::word_t mem [`SQRT_RAM_DEPTH];

    // Read before write so a write cycle returns the old word
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* hdl/sqrt_controller.sv */
`timescale 1ns/1ps
`include "sqrt_cfg.svh"

module sqrt_controller (
    input  logic              clk,
    input  logic              reset,
    input  logic              rx_empty,
    input  sqrt_pkg::byte_t   rx_data,
    output logic              rx_rd,
    input  logic              tx_empty,
    output sqrt_pkg::byte_t   tx_data,
    output logic              tx_wr,
    output logic              sq_start,
    output sqrt_pkg::rad_t    sq_radicand,
    input  sqrt_pkg::root_t   sq_root,
    input  logic              sq_done,
    output logic              ram_we,
    output sqrt_pkg::addr_t   ram_addr,
    output sqrt_pkg::word_t   ram_wdata,
    input  sqrt_pkg::word_t   ram_rdata
);

    localparam int ADDR_W = `SQRT_ADDR_W;
    localparam int RAD_W  = `SQRT_RAD_W;
    localparam int WORD_W = `SQRT_WORD_W;

    sqrt_pkg::ctrl_state_t state;
    sqrt_pkg::ctrl_state_t state_nxt;
    sqrt_pkg::sqrt_cmd_t   cmd;
    sqrt_pkg::word_t       word_q;

    logic byte_state;
    logic tx_state;
    logic rd_pending;

    //////////////////////////////
    // Queue side
    //////////////////////////////

    assign byte_state = (state == sqrt_pkg::ADDR_HI) || (state == sqrt_pkg::ADDR_LO)
                     || (state == sqrt_pkg::RAD_HI)  || (state == sqrt_pkg::RAD_LO);
    assign tx_state   = (state == sqrt_pkg::TX_HI) || (state == sqrt_pkg::TX_LO);

    // Pop only the byte taken this cycle
    assign rx_rd = byte_state && !rx_empty;

    // Hold off the first byte while the read word is still landing
    assign tx_wr   = tx_state && tx_empty && !rd_pending;
    assign tx_data = (state == sqrt_pkg::TX_HI) ? word_q[WORD_W-1 -: 8] : word_q[7:0];

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            sqrt_pkg::ADDR_HI: begin
                if (rx_rd) state_nxt = sqrt_pkg::ADDR_LO;
            end
            sqrt_pkg::ADDR_LO: begin
                if (rx_rd) state_nxt = sqrt_pkg::RAD_HI;
            end
            sqrt_pkg::RAD_HI: begin
                if (rx_rd) state_nxt = sqrt_pkg::RAD_LO;
            end
            sqrt_pkg::RAD_LO: begin
                if (rx_rd) state_nxt = sqrt_pkg::ROOT_WAIT;
            end
            sqrt_pkg::ROOT_WAIT: begin
                if (sq_done) state_nxt = sqrt_pkg::RAM_WRITE;
            end
            sqrt_pkg::RAM_WRITE: state_nxt = sqrt_pkg::RAM_READ;
            sqrt_pkg::RAM_READ:  state_nxt = sqrt_pkg::TX_HI;
            sqrt_pkg::TX_HI: begin
                if (tx_wr) state_nxt = sqrt_pkg::TX_LO;
            end
            sqrt_pkg::TX_LO: begin
                if (tx_wr) state_nxt = sqrt_pkg::ADDR_HI;
            end
            default: state_nxt = sqrt_pkg::ADDR_HI;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= sqrt_pkg::ADDR_HI;
            sq_start   <= 1'b0;
            rd_pending <= 1'b0;
        end else begin
            state      <= state_nxt;
            // Root unit starts the cycle after the last radicand byte
            sq_start   <= rx_rd && (state == sqrt_pkg::RAD_LO);
            rd_pending <= (state == sqrt_pkg::RAM_READ);
        end
    end

    //////////////////////////////
    // Command and reply word
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rx_rd) begin
            case (state)
                // Only the low address bits of the first byte count
                sqrt_pkg::ADDR_HI: cmd.addr[ADDR_W-1:8] <= rx_data[ADDR_W-9:0];
                sqrt_pkg::ADDR_LO: cmd.addr[7:0] <= rx_data;
                sqrt_pkg::RAD_HI:  cmd.radicand[RAD_W-1:8] <= rx_data[RAD_W-9:0];
                sqrt_pkg::RAD_LO:  cmd.radicand[7:0] <= rx_data;
                default: ;
            endcase
        end
        // RAM output is valid one cycle after RAM_READ
        if (rd_pending) begin
            word_q <= ram_rdata;
        end
    end

    assign sq_radicand = cmd.radicand;
    assign ram_addr    = cmd.addr;
    assign ram_we      = (state == sqrt_pkg::RAM_WRITE);
    assign ram_wdata   = sqrt_pkg::word_t'(sq_root);

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        !(rx_rd && rx_empty));

    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        !(tx_wr && !tx_empty));

    a_legal_state: assert property (@(posedge clk) disable iff (reset)
        state inside {sqrt_pkg::ADDR_HI, sqrt_pkg::ADDR_LO, sqrt_pkg::RAD_HI,
                      sqrt_pkg::RAD_LO, sqrt_pkg::ROOT_WAIT, sqrt_pkg::RAM_WRITE,
                      sqrt_pkg::RAM_READ, sqrt_pkg::TX_HI, sqrt_pkg::TX_LO});

endmodule

/* hdl/sqrt_server.sv */
`timescale 1ns/1ps

module sqrt_server (
    input  logic            clk,
    input  logic            reset,
    input  logic            rx_empty,
    input  sqrt_pkg::byte_t rx_data,
    output logic            rx_rd,
    input  logic            tx_empty,
    output sqrt_pkg::byte_t tx_data,
    output logic            tx_wr
);

    // Controller to root unit
    logic            sq_start;
    sqrt_pkg::rad_t  sq_radicand;
    sqrt_pkg::root_t sq_root;
    logic            sq_done;

    // Controller to result RAM
    logic            ram_we;
    sqrt_pkg::addr_t ram_addr;
    sqrt_pkg::word_t ram_wdata;
    sqrt_pkg::word_t ram_rdata;

    sqrt_controller u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .rx_empty    (rx_empty),
        .rx_data     (rx_data),
        .rx_rd       (rx_rd),
        .tx_empty    (tx_empty),
        .tx_data     (tx_data),
        .tx_wr       (tx_wr),
        .sq_start    (sq_start),
        .sq_radicand (sq_radicand),
        .sq_root     (sq_root),
        .sq_done     (sq_done),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata)
    );

    isqrt_unit u_sqrt (
        .clk      (clk),
        .reset    (reset),
        .start    (sq_start),
        .radicand (sq_radicand),
        .root     (sq_root),
        .done     (sq_done)
    );

    result_ram u_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

/* sim/sqrt_server_tb.sv */
`timescale 1ns/1ps

module sqrt_server_tb;

    logic            clk;
    logic            reset;
    logic            rx_empty;
    sqrt_pkg::byte_t rx_data;
    logic            rx_rd;
    logic            tx_empty;
    sqrt_pkg::byte_t tx_data;
    logic            tx_wr;

    // Queue models and scoreboard
    sqrt_pkg::byte_t rx_q[$];
    sqrt_pkg::byte_t exp_q[$];
    int              rad_q[$];
    sqrt_pkg::byte_t got_q[$];

    // Scoreboard head seen by the assertions
    sqrt_pkg::byte_t exp_byte;
    logic            exp_valid;
    int              exp_rad;
    logic            lo_next;
    int              since_rd;
    int              rd_count;

    logic            rd_seen;
    logic            wr_seen;
    sqrt_pkg::byte_t byte_seen;

    int    gap_pct;
    int    stall_pct;
    logic  quiet;
    logic  lat_check;
    string cur_test;
    int    err_count;
    int    errs_at_start;
    int    n_ok;
    int    n_bad;
    logic  timed_out;

    sqrt_server dut (
        .clk      (clk),
        .reset    (reset),
        .rx_empty (rx_empty),
        .rx_data  (rx_data),
        .rx_rd    (rx_rd),
        .tx_empty (tx_empty),
        .tx_data  (tx_data),
        .tx_wr    (tx_wr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // Reference and reporting
    //////////////////////////////

    // Largest r with r*r <= rad
    function automatic int floor_sqrt(input int rad);
        int r;
        r = 0;
        while ((r + 1) * (r + 1) <= rad) begin
            r++;
        end
        return r;
    endfunction

    function automatic void refresh_expect();
        exp_valid = (exp_q.size() > 0);
        exp_byte  = exp_valid ? exp_q[0] : 8'h00;
        exp_rad   = (rad_q.size() > 0) ? rad_q[0] : 0;
    endfunction

    function automatic void report_value(input int expv, input int actv);
        err_count++;
        $display("ERR %s expected %0d actual %0d", cur_test, expv, actv);
    endfunction

    function automatic void report_fault(input string msg);
        err_count++;
        $display("%s: %s", cur_test, msg);
    endfunction

    //////////////////////////////
    // Queue models
    //////////////////////////////

    // Outputs are settled by mid cycle
    always @(negedge clk) begin
        rd_seen   = rx_rd;
        wr_seen   = tx_wr;
        byte_seen = tx_data;
    end

    always @(posedge clk) begin
        #1;
        since_rd++;
        if (rd_seen === 1'b1 && rx_q.size() > 0) begin
            void'(rx_q.pop_front());
            // Fourth byte of a command restarts the latency count
            if (rd_count % 4 == 3) begin
                since_rd = 1;
            end
            rd_count++;
        end
        if (wr_seen === 1'b1) begin
            got_q.push_back(byte_seen);
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            if (lo_next && rad_q.size() > 0) begin
                void'(rad_q.pop_front());
            end
            lo_next = !lo_next;
        end
        refresh_expect();
        rx_empty = (rx_q.size() == 0) || ($urandom_range(99) < gap_pct);
        rx_data  = (rx_q.size() > 0) ? rx_q[0] : 8'h00;
        tx_empty = ($urandom_range(99) >= stall_pct);
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_rx_legal: assert property (@(posedge clk) disable iff (reset)
        !(rx_rd && rx_empty))
        else report_fault("rx_rd pulsed while the receive queue was empty");

    a_tx_legal: assert property (@(posedge clk) disable iff (reset)
        !(tx_wr && !tx_empty))
        else report_fault("tx_wr pulsed while the transmit queue was full");

    a_byte_match: assert property (@(posedge clk) disable iff (reset)
        tx_wr |-> (exp_valid && tx_data == exp_byte))
        else begin
            if (!$sampled(exp_valid)) begin
                report_fault("a reply byte came with no command pending");
            end else begin
                report_value($sampled(exp_byte), $sampled(tx_data));
            end
        end

    a_root_bounds: assert property (@(posedge clk) disable iff (reset)
        (tx_wr && lo_next) |-> (int'(tx_data) * int'(tx_data) <= exp_rad
            && (int'(tx_data) + 1) * (int'(tx_data) + 1) > exp_rad))
        else report_value(floor_sqrt($sampled(exp_rad)), $sampled(tx_data));

    a_first_latency: assert property (@(posedge clk) disable iff (reset)
        (lat_check && tx_wr && !lo_next) |-> since_rd == 13)
        else report_value(13, $sampled(since_rd));

    a_second_latency: assert property (@(posedge clk) disable iff (reset)
        (lat_check && tx_wr && lo_next) |-> since_rd == 14)
        else report_value(14, $sampled(since_rd));

    a_quiet: assert property (@(posedge clk) disable iff (reset)
        quiet |-> !(rx_rd || tx_wr))
        else report_value(0, $sampled({rx_rd, tx_wr}));

    //////////////////////////////
    // Test sequencing
    //////////////////////////////

    // Junk goes in the unused upper nibble of the address byte
    task automatic send_cmd(input sqrt_pkg::addr_t addr, input int rad, input logic [3:0] junk);
        sqrt_pkg::word_t w;
        w = sqrt_pkg::word_t'(floor_sqrt(rad));
        rx_q.push_back({junk, addr[11:8]});
        rx_q.push_back(addr[7:0]);
        rx_q.push_back(rad[15:8]);
        rx_q.push_back(rad[7:0]);
        exp_q.push_back(w[15:8]);
        exp_q.push_back(w[7:0]);
        rad_q.push_back(rad);
        refresh_expect();
    endtask

    task automatic send_random(input int count);
        for (int i = 0; i < count; i++) begin
            send_cmd(sqrt_pkg::addr_t'($urandom_range(4095)), $urandom_range(65535),
                     4'($urandom_range(15)));
        end
    endtask

    task automatic wait_bytes(input int count, input int limit);
        int n;
        n = 0;
        while (got_q.size() < count && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (got_q.size() < count) begin
            timed_out = 1'b1;
            report_fault($sformatf("timeout, only %0d of %0d reply bytes arrived",
                                   got_q.size(), count));
        end
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        errs_at_start = err_count;
        got_q.delete();
    endtask

    task automatic end_test();
        if (err_count == errs_at_start) begin
            n_ok++;
            $display("%s ok", cur_test);
        end else begin
            n_bad++;
            $display("%s FAILED with %0d errors", cur_test, err_count - errs_at_start);
        end
    endtask

    initial begin
        int fixed [7];
        fixed = '{0, 1, 2, 255, 256, 65535, 40000};
        void'($urandom(53131));
        reset     = 1'b1;
        rx_empty  = 1'b1;
        rx_data   = 8'h00;
        tx_empty  = 1'b1;
        rd_seen   = 1'b0;
        wr_seen   = 1'b0;
        byte_seen = 8'h00;
        lo_next   = 1'b0;
        since_rd  = 0;
        rd_count  = 0;
        gap_pct   = 0;
        stall_pct = 0;
        quiet     = 1'b0;
        lat_check = 1'b0;
        err_count = 0;
        n_ok      = 0;
        n_bad     = 0;
        timed_out = 1'b0;
        cur_test  = "reset";
        refresh_expect();
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        @(negedge clk);
        begin_test("reset_idle");
        quiet = 1'b1;
        repeat (20) @(negedge clk);
        quiet = 1'b0;
        end_test();

        begin_test("fixed_roots");
        foreach (fixed[i]) begin
            send_cmd(sqrt_pkg::addr_t'($urandom_range(4095)), fixed[i], 4'h0);
        end
        wait_bytes(14, 7 * 60);
        end_test();

        if (!timed_out) begin
            begin_test("random_roots");
            send_random(200);
            wait_bytes(400, 200 * 60);
            end_test();
        end

        if (!timed_out) begin
            begin_test("latency");
            lat_check = 1'b1;
            send_random(1);
            wait_bytes(2, 60);
            lat_check = 1'b0;
            end_test();
        end

        if (!timed_out) begin
            begin_test("stalls");
            gap_pct   = 30;
            stall_pct = 30;
            send_random(60);
            wait_bytes(120, 60 * 200);
            gap_pct   = 0;
            stall_pct = 0;
            end_test();
        end

        $display("summary: %0d ok, %0d failing, %0d errors", n_ok, n_bad, err_count);
        if (n_bad == 0 && err_count == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+hdl
hdl/sqrt_pkg.sv
hdl/isqrt_unit.sv
hdl/result_ram.sv
hdl/sqrt_controller.sv
hdl/sqrt_server.sv
sim/sqrt_server_tb.sv
